//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_srio_1x_wrapper -f verilog.f -Mdir obj_dir \
    && ./obj_dir/Vtb_srio_1x_wrapper | tee sim.log
grep -q "SIMULATION PASSED" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }

//--- srio_1x_wrapper.sv
`timescale 1ns/1ps

module srio_1x_wrapper
#(
    parameter int ONCE_LEN        = 8,         // multiple of 4
    parameter int US_DEPTH        = 8,
    parameter int DS_DEPTH        = 8,
    parameter int US_PROG_FULL    = 6,
    parameter int DS_PROG_FULL    = 6,
    parameter int LOOP_RST_CYCLES = 16
)
(
    input  logic                   clk_50m,
    input  logic                   rst_n,
    input  logic                   srio_core_rst,
    input  logic                   fiber_sw_rst,
    input  logic                   loopback_sel,       // 1 = internal loopback
    input  logic                   link_up,
    input  srio_pkg::dev_id_t      dest_id,
    input  srio_pkg::dev_id_t      device_id_set,
    output srio_pkg::dev_id_t      device_id,
    output srio_pkg::dev_id_t      source_id,
    output logic                   id_set_done,
    input  logic                   wr_en,              // upstream user words
    input  srio_pkg::word_t        wr_data,
    output logic                   prog_full,
    input  logic                   rd_en,              // downstream user words
    output srio_pkg::word_t        rd_data,
    output logic                   empty,
    output srio_pkg::link_beat_s   link_tx,
    output logic                   link_tx_valid,
    input  logic                   link_tx_ready,
    input  srio_pkg::link_beat_s   link_rx,
    input  logic                   link_rx_valid,
    output logic                   link_rx_ready
);

    import srio_pkg::*;

    localparam int AVAIL_W = $clog2(US_DEPTH * BEATS_PER_WORD + 1);

    logic               core_rst;
    logic               loop_flush;
    link_beat_s         tx_link;
    logic               tx_link_valid;
    logic               tx_link_ready;
    link_beat_s         rx_link;
    logic               rx_link_valid;
    logic               rx_link_ready;
    logic               beat_valid;
    beat_t              beat_data;
    logic               beat_pop;
    logic [AVAIL_W-1:0] beats_avail;
    logic               put;
    beat_t              put_data;
    logic               ds_prog_full;

    // ----------------------------------------
    // reset and loopback
    // ----------------------------------------
    srio_reset_ctrl u_reset_ctrl
    (
        .clk_50m       (clk_50m),
        .rst_n         (rst_n),
        .srio_core_rst (srio_core_rst),
        .fiber_sw_rst  (fiber_sw_rst),
        .loop_flush    (loop_flush),
        .core_rst      (core_rst)
    );

    srio_loopback_ctrl #(.LOOP_RST_CYCLES(LOOP_RST_CYCLES)) u_loopback
    (
        .clk_50m       (clk_50m),
        .rst_n         (rst_n),          // not core_rst, flush feeds it
        .loopback_sel  (loopback_sel),
        .loop_flush    (loop_flush),
        .tx_link       (tx_link),
        .tx_link_valid (tx_link_valid),
        .tx_link_ready (tx_link_ready),
        .link_tx       (link_tx),
        .link_tx_valid (link_tx_valid),
        .link_tx_ready (link_tx_ready),
        .link_rx       (link_rx),
        .link_rx_valid (link_rx_valid),
        .link_rx_ready (link_rx_ready),
        .rx_link       (rx_link),
        .rx_link_valid (rx_link_valid),
        .rx_link_ready (rx_link_ready)
    );

    // ----------------------------------------
    // buffers and packet engine
    // ----------------------------------------
    srio_us_buffer #(
        .US_DEPTH     (US_DEPTH),
        .US_PROG_FULL (US_PROG_FULL),
        .AVAIL_W      (AVAIL_W)
    ) u_us_buffer
    (
        .clk_50m     (clk_50m),
        .core_rst    (core_rst),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .prog_full   (prog_full),
        .beat_valid  (beat_valid),
        .beat_data   (beat_data),
        .beat_pop    (beat_pop),
        .beats_avail (beats_avail)
    );

    srio_app_fsm #(.ONCE_LEN(ONCE_LEN), .AVAIL_W(AVAIL_W)) u_app_fsm
    (
        .clk_50m       (clk_50m),
        .core_rst      (core_rst),
        .link_up       (link_up),
        .device_id_set (device_id_set),
        .dest_id       (dest_id),
        .device_id     (device_id),
        .source_id     (source_id),
        .id_set_done   (id_set_done),
        .beats_avail   (beats_avail),
        .beat_valid    (beat_valid),
        .beat_data     (beat_data),
        .beat_pop      (beat_pop),
        .tx_link       (tx_link),
        .tx_link_valid (tx_link_valid),
        .tx_link_ready (tx_link_ready),
        .rx_link       (rx_link),
        .rx_link_valid (rx_link_valid),
        .rx_link_ready (rx_link_ready),
        .put           (put),
        .put_data      (put_data),
        .ds_prog_full  (ds_prog_full)
    );

    srio_ds_buffer #(.DS_DEPTH(DS_DEPTH), .DS_PROG_FULL(DS_PROG_FULL)) u_ds_buffer
    (
        .clk_50m   (clk_50m),
        .core_rst  (core_rst),
        .put       (put),
        .put_data  (put_data),
        .prog_full (ds_prog_full),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .empty     (empty)
    );

endmodule

//--- srio_1x_wrapper_checker.sv
`timescale 1ns/1ps

module srio_1x_wrapper_checker
(
    input logic                 clk_50m,
    input logic                 rst_n,
    input logic                 core_rst,
    input srio_pkg::link_beat_s link_tx,
    input logic                 link_tx_valid,
    input logic                 link_tx_ready,
    input logic                 id_set_done
);

    // ----------------------------------------
    // link_tx stream rules
    // ----------------------------------------
    // offered beat waits for ready
    a_valid_hold: assert property (@(posedge clk_50m) disable iff (!rst_n || core_rst)
        link_tx_valid && !link_tx_ready |=> link_tx_valid)
        else $error("link_tx valid dropped before ready");

    a_beat_stable: assert property (@(posedge clk_50m) disable iff (!rst_n || core_rst)
        link_tx_valid && !link_tx_ready |=> $stable(link_tx))   // data and last
        else $error("link_tx beat changed under back-pressure");

    // id flag cleared by core reset
    a_id_reset: assert property (@(posedge clk_50m) core_rst |=> !id_set_done)
        else $error("id_set_done high during core reset");

endmodule

bind srio_1x_wrapper srio_1x_wrapper_checker u_checker
(
    .clk_50m       (clk_50m),
    .rst_n         (rst_n),
    .core_rst      (core_rst),
    .link_tx       (link_tx),
    .link_tx_valid (link_tx_valid),
    .link_tx_ready (link_tx_ready),
    .id_set_done   (id_set_done)
);

//--- srio_app_fsm.sv
`timescale 1ns/1ps

module srio_app_fsm
#(
    parameter int ONCE_LEN = 8,
    parameter int AVAIL_W  = 6
)
(
    input  logic                   clk_50m,
    input  logic                   core_rst,
    input  logic                   link_up,
    input  srio_pkg::dev_id_t      device_id_set,
    input  srio_pkg::dev_id_t      dest_id,
    output srio_pkg::dev_id_t      device_id,
    output srio_pkg::dev_id_t      source_id,
    output logic                   id_set_done,
    input  logic [AVAIL_W-1:0]     beats_avail,
    input  logic                   beat_valid,
    input  srio_pkg::beat_t        beat_data,
    output logic                   beat_pop,
    output srio_pkg::link_beat_s   tx_link,
    output logic                   tx_link_valid,
    input  logic                   tx_link_ready,
    input  srio_pkg::link_beat_s   rx_link,
    input  logic                   rx_link_valid,
    output logic                   rx_link_ready,
    output logic                   put,
    output srio_pkg::beat_t        put_data,
    input  logic                   ds_prog_full
);

    import srio_pkg::*;

    localparam int CNT_W = $clog2(ONCE_LEN + 1);

    tx_state_e        tx_state;
    rx_state_e        rx_state;
    logic [CNT_W-1:0] tx_cnt;                  // payload beats loaded
    pkt_hdr_s         tx_hdr;
    pkt_hdr_s         rx_hdr;
    logic             tx_start;
    logic             rx_take;

    // ----------------------------------------
    // device id
    // ----------------------------------------
    always_ff @(posedge clk_50m)
    begin
        if (core_rst)
            id_set_done <= 1'b0;
        else if (!id_set_done)
        begin
            device_id   <= device_id_set;      // first cycle out of reset
            id_set_done <= 1'b1;
        end
    end

    assign source_id = device_id;

    // ----------------------------------------
    // transmit framer
    // ----------------------------------------
    assign tx_hdr   = '{dest_id: dest_id, source_id: device_id, beat_cnt: 32'(ONCE_LEN)};
    assign tx_start = link_up && id_set_done && beat_valid
                    && (beats_avail >= AVAIL_W'(ONCE_LEN));    // whole packet on hand

    // pop the beat that is loaded into the output register
    assign beat_pop = tx_link_ready
                    && ((tx_state == TX_HEADER) || (tx_state == TX_PAYLOAD && !tx_link.last));

    always_ff @(posedge clk_50m)
    begin
        if (core_rst)
        begin
            tx_state      <= TX_IDLE;
            tx_link_valid <= 1'b0;
            tx_cnt        <= '0;
        end
        else
        begin
            case (tx_state)
                TX_IDLE:
                    if (tx_start)
                    begin
                        tx_link       <= '{data: beat_t'(tx_hdr), last: 1'b0};
                        tx_link_valid <= 1'b1;
                        tx_state      <= TX_HEADER;
                    end
                TX_HEADER:
                    if (tx_link_ready)                 // header taken
                    begin
                        tx_link  <= '{data: beat_data, last: 1'b0};  // ONCE_LEN >= 4
                        tx_cnt   <= CNT_W'(1);
                        tx_state <= TX_PAYLOAD;
                    end
                TX_PAYLOAD:
                    if (tx_link_ready)
                    begin
                        if (tx_link.last)
                        begin
                            tx_link_valid <= 1'b0;
                            tx_state      <= TX_IDLE;
                        end
                        else
                        begin
                            tx_link <= '{data: beat_data,
                                         last: (tx_cnt == CNT_W'(ONCE_LEN - 1))};
                            tx_cnt  <= tx_cnt + 1'b1;
                        end
                    end
                default:
                    tx_state <= TX_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // receive deframer
    // ----------------------------------------
    assign rx_link_ready = id_set_done && !ds_prog_full;   // closed until id is known
    assign rx_take       = rx_link_valid && rx_link_ready;
    assign rx_hdr        = pkt_hdr_s'(rx_link.data);
    assign put           = rx_take && (rx_state == RX_ACCEPT);
    assign put_data      = rx_link.data;

    always_ff @(posedge clk_50m)
    begin
        if (core_rst)
            rx_state <= RX_HEADER;
        else if (rx_take)
        begin
            if (rx_link.last)
                rx_state <= RX_HEADER;             // end of packet, or empty one
            else if (rx_state == RX_HEADER)
                rx_state <= (rx_hdr.dest_id == device_id) ? RX_ACCEPT : RX_DISCARD;
        end
    end

endmodule

//--- srio_ds_buffer.sv
`timescale 1ns/1ps

module srio_ds_buffer
#(
    parameter int DS_DEPTH     = 8,
    parameter int DS_PROG_FULL = 6
)
(
    input  logic              clk_50m,
    input  logic              core_rst,
    input  logic              put,
    input  srio_pkg::beat_t   put_data,
    output logic              prog_full,
    input  logic              rd_en,
    output srio_pkg::word_t   rd_data,
    output logic              empty
);

    import srio_pkg::*;

    localparam int PTR_W = $clog2(DS_DEPTH);
    localparam int CNT_W = $clog2(DS_DEPTH + 1);
    localparam int IDX_W = $clog2(BEATS_PER_WORD);

    word_t            mem [DS_DEPTH];
    word_t            gather;                  // partial word
    word_t            gather_next;
    logic [IDX_W-1:0] gather_idx;              // slot for the next beat
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] word_cnt;
    logic             push;
    logic             pop;

    // ----------------------------------------
    // beat packing
    // ----------------------------------------
    always_comb
    begin
        gather_next = gather;
        gather_next[gather_idx*BEAT_W +: BEAT_W] = put_data;
    end

    // fourth beat completes the word, full fifo drops it
    assign push = put && (gather_idx == IDX_W'(BEATS_PER_WORD - 1))
                && (word_cnt != CNT_W'(DS_DEPTH));
    assign pop  = rd_en && !empty;

    always_ff @(posedge clk_50m)
    begin
        if (put)
            gather <= gather_next;
        if (push)
            mem[wr_ptr] <= gather_next;
    end

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk_50m)
    begin
        if (core_rst)
        begin
            gather_idx <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            word_cnt   <= '0;
        end
        else
        begin
            if (put)
                gather_idx <= gather_idx + 1'b1;   // wraps after the fourth
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DS_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DS_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            word_cnt <= word_cnt + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // ----------------------------------------
    // fwft read side
    // ----------------------------------------
    assign rd_data   = mem[rd_ptr];                // head word, valid while !empty
    assign empty     = (word_cnt == '0);
    assign prog_full = (word_cnt >= CNT_W'(DS_PROG_FULL));

endmodule

//--- srio_loopback_ctrl.sv
`timescale 1ns/1ps

module srio_loopback_ctrl
#(
    parameter int LOOP_RST_CYCLES = 16
)
(
    input  logic                   clk_50m,
    input  logic                   rst_n,
    input  logic                   loopback_sel,
    output logic                   loop_flush,
    input  srio_pkg::link_beat_s   tx_link,        // from app
    input  logic                   tx_link_valid,
    output logic                   tx_link_ready,
    output srio_pkg::link_beat_s   link_tx,        // to the link
    output logic                   link_tx_valid,
    input  logic                   link_tx_ready,
    input  srio_pkg::link_beat_s   link_rx,        // from the link
    input  logic                   link_rx_valid,
    output logic                   link_rx_ready,
    output srio_pkg::link_beat_s   rx_link,        // to app
    output logic                   rx_link_valid,
    input  logic                   rx_link_ready
);

    localparam int CNT_W = $clog2(LOOP_RST_CYCLES + 1);

    logic             sel_r1;
    logic             sel_r2;
    logic             loop_en;                     // active loopback
    logic [CNT_W-1:0] flush_cnt;

    // ----------------------------------------
    // selection sync and flush pulse
    // ----------------------------------------
    always_ff @(posedge clk_50m)
    begin
        if (!rst_n)
        begin
            sel_r1     <= 1'b0;
            sel_r2     <= 1'b0;
            loop_en    <= 1'b0;
            loop_flush <= 1'b0;
            flush_cnt  <= '0;
        end
        else
        begin
            sel_r1 <= loopback_sel;
            sel_r2 <= sel_r1;
            if (sel_r2 != loop_en)                 // selection changed
            begin
                loop_en    <= sel_r2;
                loop_flush <= 1'b1;
                flush_cnt  <= CNT_W'(LOOP_RST_CYCLES - 1);
            end
            else if (loop_flush)
            begin
                if (flush_cnt == '0)
                    loop_flush <= 1'b0;            // pulse done
                else
                    flush_cnt <= flush_cnt - 1'b1;
            end
        end
    end

    // ----------------------------------------
    // stream routing
    // ----------------------------------------
    assign link_tx       = tx_link;
    assign link_tx_valid = tx_link_valid & ~loop_en;   // link silent in loopback
    assign link_rx_ready = rx_link_ready & ~loop_en;

    assign rx_link       = loop_en ? tx_link : link_rx;
    assign rx_link_valid = loop_en ? tx_link_valid : link_rx_valid;
    assign tx_link_ready = loop_en ? rx_link_ready : link_tx_ready;

endmodule

//--- srio_pkg.sv
package srio_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    parameter int BEAT_W         = 64;      // link beat
    parameter int WORD_W         = 256;     // user word
    parameter int BEATS_PER_WORD = WORD_W / BEAT_W;
    parameter int ID_W           = 16;      // rapidio small/large id

    typedef logic [BEAT_W-1:0] beat_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ID_W-1:0]   dev_id_t;

    // ----------------------------------------
    // link stream payload
    // ----------------------------------------
    typedef struct packed
    {
        beat_t data;
        logic  last;                        // final beat of a packet
    } link_beat_s;

    // header beat layout, msb first
    typedef struct packed
    {
        dev_id_t     dest_id;
        dev_id_t     source_id;
        logic [31:0] beat_cnt;              // payload beats that follow
    } pkt_hdr_s;

    // ----------------------------------------
    // fsm states
    // ----------------------------------------
    typedef enum logic [1:0]
    {
        TX_IDLE,
        TX_HEADER,
        TX_PAYLOAD
    } tx_state_e;

    typedef enum logic [1:0]
    {
        RX_HEADER,
        RX_ACCEPT,
        RX_DISCARD
    } rx_state_e;

endpackage

//--- srio_reset_ctrl.sv
`timescale 1ns/1ps

module srio_reset_ctrl
(
    input  logic clk_50m,
    input  logic rst_n,
    input  logic srio_core_rst,
    input  logic fiber_sw_rst,
    input  logic loop_flush,
    output logic core_rst
);

    // ----------------------------------------
    // fiber soft reset sync
    // ----------------------------------------
    logic fiber_sw_rst_r1;
    logic fiber_sw_rst_r2;

    always_ff @(posedge clk_50m)
    begin
        if (!rst_n)
        begin
            fiber_sw_rst_r1 <= 1'b0;
            fiber_sw_rst_r2 <= 1'b0;
        end
        else
        begin
            fiber_sw_rst_r1 <= fiber_sw_rst;        // async source
            fiber_sw_rst_r2 <= fiber_sw_rst_r1;
        end
    end

    // ----------------------------------------
    // merge of all reset causes
    // ----------------------------------------
    // core_rst follows any cause by one cycle
    always_ff @(posedge clk_50m)
    begin
        core_rst <= !rst_n             // board reset
                  | srio_core_rst      // software core reset
                  | fiber_sw_rst_r2    // fiber side reset, synced
                  | loop_flush;        // loopback change
    end

endmodule

//--- srio_us_buffer.sv
`timescale 1ns/1ps

module srio_us_buffer
#(
    parameter int US_DEPTH     = 8,
    parameter int US_PROG_FULL = 6,
    parameter int AVAIL_W      = 6
)
(
    input  logic                 clk_50m,
    input  logic                 core_rst,
    input  logic                 wr_en,
    input  srio_pkg::word_t      wr_data,
    output logic                 prog_full,
    output logic                 beat_valid,
    output srio_pkg::beat_t      beat_data,
    input  logic                 beat_pop,
    output logic [AVAIL_W-1:0]   beats_avail
);

    import srio_pkg::*;

    localparam int PTR_W = $clog2(US_DEPTH);
    localparam int CNT_W = $clog2(US_DEPTH + 1);
    localparam int IDX_W = $clog2(BEATS_PER_WORD);

    word_t            mem [US_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] word_cnt;                // words held, head included
    logic [IDX_W-1:0] beat_idx;                // next beat of head word
    logic             push;
    logic             take;
    logic             pop_word;

    assign push     = wr_en && (word_cnt != CNT_W'(US_DEPTH));  // full drops
    assign take     = beat_pop && beat_valid;
    assign pop_word = take && (beat_idx == IDX_W'(BEATS_PER_WORD - 1));

    // ----------------------------------------
    // word storage
    // ----------------------------------------
    always_ff @(posedge clk_50m)
    begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    // ----------------------------------------
    // pointers and counts
    // ----------------------------------------
    always_ff @(posedge clk_50m)
    begin
        if (core_rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            word_cnt <= '0;
            beat_idx <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(US_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_word)                              // head word used up
                rd_ptr <= (rd_ptr == PTR_W'(US_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (take)
                beat_idx <= pop_word ? '0 : beat_idx + 1'b1;
            word_cnt <= word_cnt + CNT_W'(push) - CNT_W'(pop_word);
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign beat_valid  = (word_cnt != '0);
    assign beat_data   = mem[rd_ptr][beat_idx*BEAT_W +: BEAT_W];   // low beat first
    assign prog_full   = (word_cnt >= CNT_W'(US_PROG_FULL));
    assign beats_avail = AVAIL_W'(word_cnt * BEATS_PER_WORD - beat_idx);

endmodule

//--- tb_srio_1x_wrapper.sv
`timescale 1ns/1ps

module tb_srio_1x_wrapper;

    import srio_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int ONCE_LEN      = 8;
    localparam int US_DEPTH      = 8;
    localparam int US_PROG_FULL  = 6;
    localparam int WORDS_PER_PKT = ONCE_LEN / BEATS_PER_WORD;
    localparam dev_id_t MY_ID    = 16'h00a5;
    localparam dev_id_t OTHER_ID = 16'h0123;
    localparam dev_id_t PEER_ID  = 16'h0077;     // source of external packets

    // cycle budget per test for the watchdog
    localparam int T1_CYC     = 60;
    localparam int T2_CYC     = 300;
    localparam int T3_CYC     = 300;
    localparam int T4_CYC     = 300;
    localparam int T5_CYC     = 600;
    localparam int MARGIN_CYC = 400;

    logic       clk_50m;
    logic       rst_n;
    logic       srio_core_rst;
    logic       fiber_sw_rst;
    logic       loopback_sel;
    logic       link_up;
    dev_id_t    dest_id;
    dev_id_t    device_id_set;
    dev_id_t    device_id;
    dev_id_t    source_id;
    logic       id_set_done;
    logic       wr_en;
    word_t      wr_data;
    logic       prog_full;
    logic       rd_en;
    word_t      rd_data;
    logic       empty;
    link_beat_s link_tx;
    logic       link_tx_valid;
    logic       link_tx_ready;
    link_beat_s link_rx;
    logic       link_rx_valid;
    logic       link_rx_ready;

    logic [15:0] lfsr_q = 16'd26;               // seed
    string       test_name;
    bit          tx_quiet;                      // link_tx must stay idle
    bit          verdict_done;
    link_beat_s  exp_tx_q[$];                   // expected link_tx beats
    word_t       exp_rd_q[$];                   // expected rd_data words

    srio_1x_wrapper #(
        .ONCE_LEN        (ONCE_LEN),
        .US_DEPTH        (US_DEPTH),
        .DS_DEPTH        (8),
        .US_PROG_FULL    (US_PROG_FULL),
        .DS_PROG_FULL    (6),
        .LOOP_RST_CYCLES (16)
    ) uut (.*);

    initial
    begin
        clk_50m = 1'b0;
        forever #(CLK_PERIOD / 2) clk_50m = ~clk_50m;
    end

    // ----------------------------------------
    // random source on x^16+x^14+x^13+x^11+1
    // ----------------------------------------
    function automatic logic rand_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[WORD_W-2:0], rand_bit()};   // one step per bit
        return v;
    endfunction

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // header beat with dest id on top, then source id and beat count
    function automatic beat_t header_beat(dev_id_t dst, dev_id_t src, logic [31:0] cnt);
        return {dst, src, cnt};
    endfunction

    // first beat of a group lands in the lowest bits
    function automatic word_t pack_word(beat_t b0, beat_t b1, beat_t b2, beat_t b3);
        return {b3, b2, b1, b0};
    endfunction

    task automatic fail_stop();
        verdict_done = 1'b1;
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(string what, word_t exp, word_t got);
        assert (got === exp)
        else
        begin
            $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, exp, got);
            fail_stop();
        end
    endtask

    // next edge plus drive delay with new random ready and read strobe
    task automatic tick();
        @(posedge clk_50m);
        #2;
        link_tx_ready = rand_bit();
        rd_en         = rand_bit();
    endtask

    task automatic wait_id(logic level, int limit);
        int n;
        n = 0;
        while (id_set_done !== level)
        begin
            if (n >= limit)
            begin
                $display("id_set_done did not reach %0b within %0d cycles", level, limit);
                fail_stop();
            end
            else
            begin
                tick();
                n++;
            end
        end
    endtask

    // until both expected queues are used up
    task automatic wait_done(int limit);
        int n;
        n = 0;
        while (exp_tx_q.size() != 0 || exp_rd_q.size() != 0)
        begin
            if (n >= limit)
            begin
                $display("expected traffic still pending after %0d cycles", limit);
                fail_stop();
            end
            else
            begin
                tick();
                n++;
            end
        end
    endtask

    task automatic set_loopback(logic sel);
        loopback_sel = sel;
        wait_id(1'b0, 40);                      // flush reset seen
        wait_id(1'b1, 60);                      // id reloaded
    endtask

    // expected traffic queued on the side where the user words show up
    task automatic write_words(int n, bit via_loop);
        word_t      w;
        link_beat_s lb;
        for (int i = 0; i < n; i++)
        begin
            w = rand_bits(WORD_W);
            if (via_loop)
                exp_rd_q.push_back(w);          // header is stripped on receive
            else
            begin
                if (i % WORDS_PER_PKT == 0)
                begin
                    lb = '{data: header_beat(dest_id, MY_ID, ONCE_LEN), last: 1'b0};
                    exp_tx_q.push_back(lb);
                end
                for (int j = 0; j < BEATS_PER_WORD; j++)
                begin
                    lb.data = w[j*BEAT_W +: BEAT_W];   // low beat first
                    lb.last = (i % WORDS_PER_PKT == WORDS_PER_PKT - 1) && (j == 3);
                    exp_tx_q.push_back(lb);
                end
            end
            wr_data = w;
            wr_en   = 1'b1;
            tick();
        end
        wr_en = 1'b0;
    endtask

    task automatic send_rx_beat(beat_t d, logic last);
        logic took;
        int   n;
        link_rx       = '{data: d, last: last};
        link_rx_valid = 1'b1;
        took          = 1'b0;
        n             = 0;
        while (!took)
        begin
            if (n >= 100)
            begin
                $display("link_rx beat not accepted within 100 cycles");
                fail_stop();
            end
            else
            begin
                @(negedge clk_50m);
                took = link_rx_ready;           // beat moves at the next edge
                tick();
                n++;
            end
        end
        link_rx_valid = 1'b0;
    endtask

    task automatic send_rx_packet(dev_id_t dst, bit keep);
        beat_t b[BEATS_PER_WORD];
        beat_t d;
        send_rx_beat(header_beat(dst, PEER_ID, ONCE_LEN), 1'b0);
        for (int i = 0; i < ONCE_LEN; i++)
        begin
            d            = beat_t'(rand_bits(BEAT_W));
            b[i % 4]     = d;
            if (keep && (i % 4 == 3))
                exp_rd_q.push_back(pack_word(b[0], b[1], b[2], b[3]));
            send_rx_beat(d, i == ONCE_LEN - 1);
        end
    endtask

    // ----------------------------------------
    // compare process sampled mid cycle
    // ----------------------------------------
    always @(negedge clk_50m)
    begin
        link_beat_s exp_b;
        word_t      exp_w;
        if (link_tx_valid === 1'b1 && link_tx_ready === 1'b1)
        begin
            if (exp_tx_q.size() == 0)
            begin
                $display("unexpected beat on link_tx in test %s", test_name);
                fail_stop();
            end
            else
            begin
                exp_b = exp_tx_q.pop_front();
                check_val("link_tx beat", word_t'(exp_b), word_t'(link_tx));
            end
        end
        if (rd_en === 1'b1 && empty === 1'b0)   // fwft pop
        begin
            if (exp_rd_q.size() == 0)
            begin
                $display("unexpected word at rd_data in test %s", test_name);
                fail_stop();
            end
            else
            begin
                exp_w = exp_rd_q.pop_front();
                check_val("rd_data", exp_w, rd_data);
            end
        end
        if (tx_quiet)
        begin
            assert (link_tx_valid === 1'b0)
            else
            begin
                $display("link_tx valid went high while loopback is on");
                fail_stop();
            end
        end
    end

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial
    begin
        rst_n         = 1'b0;
        srio_core_rst = 1'b0;
        fiber_sw_rst  = 1'b0;
        loopback_sel  = 1'b0;
        link_up       = 1'b0;
        dest_id       = OTHER_ID;
        device_id_set = MY_ID;
        wr_en         = 1'b0;
        wr_data       = '0;
        rd_en         = 1'b0;
        link_tx_ready = 1'b0;
        link_rx       = '0;
        link_rx_valid = 1'b0;
        tx_quiet      = 1'b0;
        verdict_done  = 1'b0;

        test_name = "reset";
        repeat (3) @(posedge clk_50m);
        #2;
        check_val("link_tx_valid", '0, word_t'(link_tx_valid));
        check_val("prog_full", '0, word_t'(prog_full));
        check_val("id_set_done", '0, word_t'(id_set_done));
        check_val("link_rx_ready", '0, word_t'(link_rx_ready));
        check_val("empty", word_t'(1), word_t'(empty));
        rst_n = 1'b1;
        wait_id(1'b1, T1_CYC);
        check_val("device_id", word_t'(MY_ID), word_t'(device_id));
        check_val("source_id", word_t'(MY_ID), word_t'(source_id));

        test_name = "transmit";
        link_up   = 1'b1;
        write_words(WORDS_PER_PKT, 1'b0);       // one packet out on link_tx
        wait_done(T2_CYC);

        test_name = "receive";
        send_rx_packet(MY_ID, 1'b1);
        wait_done(T3_CYC);
        send_rx_packet(OTHER_ID, 1'b0);         // filtered by dest id
        repeat (20) tick();
        check_val("empty", word_t'(1), word_t'(empty));

        test_name = "loopback";
        set_loopback(1'b1);
        tx_quiet = 1'b1;
        dest_id  = MY_ID;
        write_words(WORDS_PER_PKT, 1'b1);
        wait_done(T4_CYC);
        tx_quiet = 1'b0;

        test_name = "flow control";
        set_loopback(1'b0);
        link_up = 1'b0;                         // hold everything upstream
        dest_id = OTHER_ID;
        write_words(US_DEPTH, 1'b0);
        check_val("prog_full", word_t'(1), word_t'(prog_full));
        link_up = 1'b1;
        wait_done(T5_CYC);
        check_val("prog_full", '0, word_t'(prog_full));

        verdict_done = 1'b1;
        $display("SIMULATION PASSED");
        $finish;
    end

    // watchdog
    initial
    begin
        #(CLK_PERIOD * (T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + MARGIN_CYC));
        verdict_done = 1'b1;
        $display("watchdog expired, the tests did not finish in time");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    // run stopped by a bound assertion
    final
    begin
        if (!verdict_done)
            $display("SIMULATION FAILED");
    end

endmodule

//--- verilog.f
srio_pkg.sv
srio_reset_ctrl.sv
srio_loopback_ctrl.sv
srio_us_buffer.sv
srio_ds_buffer.sv
srio_app_fsm.sv
srio_1x_wrapper.sv
srio_1x_wrapper_checker.sv
tb_srio_1x_wrapper.sv
